// ==== include/msg_config.svh ====
`ifndef MSG_CONFIG_SVH
`define MSG_CONFIG_SVH

// ==============================
// Host message format
// ==============================
`define MSG_LEN             64
`define MSG_TYPE_LEN        8
`define MSG_ARG_LEN         56
`define RESP_LEN            64

// Input stages beyond the inherent two cycles of turnaround
`define TURNAROUND_EXTRA    6

// Counter reload covering the whole message plus turnaround
`define MSG_CYCLES          (`MSG_LEN + `TURNAROUND_EXTRA - 2)

// Type bit asking for a response
`define TYPE_RESP_BIT       6

// Message type codes
`define TYPE_NOP            8'h80
`define TYPE_LEDSET         8'h81
`define TYPE_ECHO           8'hC0
`define TYPE_SDSTATUS       8'hC2

// ==============================
// CMD6 access-mode capture
// ==============================
`define DATIN_WORD_LEN      16
`define DATIN_BLOCK_WORDS   32
`define CMD6_MODE_WORD      23
`define CMD6_MODE_MSB       11
`define CMD6_MODE_LSB       8

`endif

// ==== rtl/msg_pkg.sv ====
`include "msg_config.svh"

package msg_pkg;

    // Incoming message, type byte first on the wire
    typedef struct packed {
        logic [`MSG_TYPE_LEN-1:0] msg_type;
        logic [`MSG_ARG_LEN-1:0]  arg;
    } msg_t;

    // LED value sits in the low nibble of the argument
    typedef struct packed {
        logic [`MSG_ARG_LEN-5:0] unused;
        logic [3:0]              led;
    } led_set_arg_t;

    // Same argument word, read per message type
    typedef union packed {
        logic [`MSG_ARG_LEN-1:0] echo;
        led_set_arg_t            led_set;
    } msg_arg_u;

    // Response word, shifted out MSB first
    typedef logic [`RESP_LEN-1:0] resp_t;

    // Seen flag lands on response bit 4, mode on bits 3..0
    typedef struct packed {
        logic       seen;
        logic [3:0] access_mode;
    } cmd6_status_t;

    // Shared counter covers both reception and response lengths
    localparam int CYCLE_CNT_MAX = (`MSG_CYCLES > `RESP_LEN) ? `MSG_CYCLES : `RESP_LEN;
    localparam int CYCLE_CNT_W   = $clog2(CYCLE_CNT_MAX + 1);

    typedef logic [CYCLE_CNT_W-1:0] cycle_cnt_t;

endpackage

// ==== rtl/cycle_counter.sv ====
`timescale 1ns/1ps
`include "msg_config.svh"

module cycle_counter
    import msg_pkg::*;
(
    input  logic sd_datInWrite_clk,
    input  logic sd_datInWrite_rst_,
    input  logic load_msg,
    input  logic load_resp,
    output logic count_zero
);

    cycle_cnt_t count;

    // Reload on request, else count down and park at zero
    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            count <= '0;
        end else if (load_msg) begin
            count <= cycle_cnt_t'(`MSG_CYCLES);
        end else if (load_resp) begin
            count <= cycle_cnt_t'(`RESP_LEN);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign count_zero = (count == '0);

endmodule

// ==== rtl/msg_fsm.sv ====
`timescale 1ns/1ps
`include "msg_config.svh"

module msg_fsm
    import msg_pkg::*;
(
    input  logic sd_datInWrite_clk,
    input  logic sd_datInWrite_rst_,
    input  logic data_in,
    input  msg_t msg,
    input  logic count_zero,
    output logic load_msg,
    output logic load_resp,
    output logic exec_strobe,
    output logic data_out_en
);

    localparam logic [1:0] ST_IDLE    = 2'd0;
    localparam logic [1:0] ST_RECEIVE = 2'd1;
    localparam logic [1:0] ST_EXECUTE = 2'd2;
    localparam logic [1:0] ST_RESPOND = 2'd3;

    logic [1:0] state;
    logic       known_type;
    logic       resp_req;

    // Unknown types fall back to Nop, so they never answer
    assign known_type = (msg.msg_type == `TYPE_ECHO)   ||
                        (msg.msg_type == `TYPE_LEDSET) ||
                        (msg.msg_type == `TYPE_SDSTATUS) ||
                        (msg.msg_type == `TYPE_NOP);
    assign resp_req = known_type && msg.msg_type[`TYPE_RESP_BIT];

    // First high bit on the line is the start marker
    assign load_msg    = (state == ST_IDLE) && data_in;
    assign exec_strobe = (state == ST_EXECUTE);
    assign load_resp   = exec_strobe && resp_req;

    // Counter was loaded with the response length on entry
    assign data_out_en = (state == ST_RESPOND) && !count_zero;

    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (data_in) begin
                        state <= ST_RECEIVE;
                    end
                end
                // Message is fully aligned once the count runs out
                ST_RECEIVE: begin
                    if (count_zero) begin
                        state <= ST_EXECUTE;
                    end
                end
                ST_EXECUTE: begin
                    state <= resp_req ? ST_RESPOND : ST_IDLE;
                end
                ST_RESPOND: begin
                    if (count_zero) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== rtl/msg_shifter.sv ====
`timescale 1ns/1ps
`include "msg_config.svh"

module msg_shifter
    import msg_pkg::*;
(
    input  logic sd_datInWrite_clk,
    input  logic sd_datInWrite_rst_,
    input  logic data_in,
    output msg_t msg
);

    logic [`TURNAROUND_EXTRA-1:0] delay_line;
    logic [`MSG_LEN-1:0]          msg_reg;

    // ==============================
    // Turnaround delay
    // ==============================
    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            delay_line <= '0;
        end else begin
            delay_line <= {delay_line[`TURNAROUND_EXTRA-2:0], data_in};
        end
    end

    // ==============================
    // Message shift register
    // ==============================
    // Start bit reaches the top just as the FSM enters execute
    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            msg_reg <= '0;
        end else begin
            msg_reg <= {msg_reg[`MSG_LEN-2:0], delay_line[`TURNAROUND_EXTRA-1]};
        end
    end

    assign msg = msg_reg;

endmodule

// ==== rtl/resp_shifter.sv ====
`timescale 1ns/1ps

module resp_shifter
    import msg_pkg::*;
(
    input  logic  sd_datInWrite_clk,
    input  logic  sd_datInWrite_rst_,
    input  logic  resp_load,
    input  resp_t resp_word,
    output logic  data_out
);

    resp_t resp_reg;

    // MSB goes straight out on load, the rest follows one per cycle
    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            resp_reg <= '0;
            data_out <= 1'b0;
        end else if (resp_load) begin
            resp_reg <= {resp_word[$bits(resp_t)-2:0], 1'b0};
            data_out <= resp_word[$bits(resp_t)-1];
        end else begin
            resp_reg <= {resp_reg[$bits(resp_t)-2:0], 1'b0};
            data_out <= resp_reg[$bits(resp_t)-1];
        end
    end

endmodule

// ==== rtl/cmd_exec.sv ====
`timescale 1ns/1ps
`include "msg_config.svh"

module cmd_exec
    import msg_pkg::*;
(
    input  logic         sd_datInWrite_clk,
    input  logic         sd_datInWrite_rst_,
    input  logic         exec_strobe,
    input  msg_t         msg,
    input  cmd6_status_t cmd6_status,
    output logic [3:0]   led,
    output resp_t        resp_word,
    output logic         resp_load
);

    msg_arg_u arg;

    assign arg = msg.arg;

    // ==============================
    // Response word
    // ==============================
    always_comb begin
        resp_word = '0;
        case (msg.msg_type)
            // Top byte stays zero, argument echoed below it
            `TYPE_ECHO: begin
                resp_word[`MSG_ARG_LEN-1:0] = arg.echo;
            end
            `TYPE_SDSTATUS: begin
                resp_word[$bits(cmd6_status_t)-1:0] = cmd6_status;
            end
            // LEDSet, Nop and unknown types send nothing
            default: begin
                resp_word = '0;
            end
        endcase
    end

    // Shifter takes the word in the execute cycle itself
    assign resp_load = exec_strobe;

    // ==============================
    // LED register
    // ==============================
    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            led <= '0;
        end else if (exec_strobe && (msg.msg_type == `TYPE_LEDSET)) begin
            led <= arg.led_set.led;
        end
    end

endmodule

// ==== rtl/cmd6_capture.sv ====
`timescale 1ns/1ps
`include "msg_config.svh"

module cmd6_capture
    import msg_pkg::*;
(
    input  logic                       sd_datInWrite_clk,
    input  logic                       sd_datInWrite_rst_,
    input  logic                       wr_trigger,
    input  logic [`DATIN_WORD_LEN-1:0] wr_data,
    output cmd6_status_t               cmd6_status
);

    localparam int WORD_CNT_W = $clog2(`DATIN_BLOCK_WORDS);

    logic [WORD_CNT_W-1:0] word_cnt;

    // Counts down from the top, wrapping once per block
    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            word_cnt    <= '1;
            cmd6_status <= '0;
        end else if (wr_trigger) begin
            word_cnt <= word_cnt - 1'b1;
            // Ninth word of the block holds the access mode
            if (word_cnt == WORD_CNT_W'(`CMD6_MODE_WORD)) begin
                cmd6_status.access_mode <= wr_data[`CMD6_MODE_MSB:`CMD6_MODE_LSB];
                cmd6_status.seen        <= 1'b1;
            end
        end
    end

endmodule

// ==== rtl/spi_msg_top.sv ====
`timescale 1ns/1ps

module spi_msg_top
    import msg_pkg::*;
(
    input  logic        sd_datInWrite_clk,
    input  logic        sd_datInWrite_rst_,
    input  logic        data_in,
    input  logic        wr_trigger,
    input  logic [15:0] wr_data,
    output logic        data_out,
    output logic        data_out_en,
    output logic [3:0]  led
);

    msg_t         msg;
    cmd6_status_t cmd6_status;
    resp_t        resp_word;
    logic         resp_load;
    logic         load_msg;
    logic         load_resp;
    logic         exec_strobe;
    logic         count_zero;

    // ==============================
    // Message path
    // ==============================
    msg_shifter i_msg_shifter (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .data_in            (data_in),
        .msg                (msg)
    );

    msg_fsm i_msg_fsm (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .data_in            (data_in),
        .msg                (msg),
        .count_zero         (count_zero),
        .load_msg           (load_msg),
        .load_resp          (load_resp),
        .exec_strobe        (exec_strobe),
        .data_out_en        (data_out_en)
    );

    cycle_counter i_cycle_counter (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .load_msg           (load_msg),
        .load_resp          (load_resp),
        .count_zero         (count_zero)
    );

    cmd_exec i_cmd_exec (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .exec_strobe        (exec_strobe),
        .msg                (msg),
        .cmd6_status        (cmd6_status),
        .led                (led),
        .resp_word          (resp_word),
        .resp_load          (resp_load)
    );

    resp_shifter i_resp_shifter (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .resp_load          (resp_load),
        .resp_word          (resp_word),
        .data_out           (data_out)
    );

    // Data-in word stream
    cmd6_capture i_cmd6_capture (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .wr_trigger         (wr_trigger),
        .wr_data            (wr_data),
        .cmd6_status        (cmd6_status)
    );

endmodule

// ==== verification/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter realtime PERIOD       = 4.0,
    parameter int      RESET_CYCLES = 5
) (
    output logic sd_datInWrite_clk,
    output logic sd_datInWrite_rst_
);

    initial begin
        sd_datInWrite_clk = 1'b0;
        forever begin
            #(PERIOD / 2.0) sd_datInWrite_clk = ~sd_datInWrite_clk;
        end
    end

    // Release off the edge, same offset as the stimulus
    initial begin
        sd_datInWrite_rst_ = 1'b0;
        repeat (RESET_CYCLES) @(posedge sd_datInWrite_clk);
        #0.5 sd_datInWrite_rst_ = 1'b1;
    end

endmodule

// ==== verification/tb_spi_msg.sv ====
`timescale 1ns/1ps
`include "msg_config.svh"

module tb_spi_msg;

    localparam realtime CLK_PERIOD      = 4.0;
    localparam int      WATCHDOG_CYCLES = 8 * 200 + 400;

    logic        sd_datInWrite_clk;
    logic        sd_datInWrite_rst_;
    logic        data_in;
    logic        wr_trigger;
    logic [15:0] wr_data;
    logic        data_out;
    logic        data_out_en;
    logic [3:0]  led;

    // Windows in which the DUT may answer or change the LEDs
    logic resp_allowed;
    logic led_allowed;

    int errors;
    int checks;
    int tests_run;
    int tests_failed;
    int err_mark;

    tb_clk_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(5)) i_tb_clk_gen (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_)
    );

    spi_msg_top i_spi_msg_top (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .data_in            (data_in),
        .wr_trigger         (wr_trigger),
        .wr_data            (wr_data),
        .data_out           (data_out),
        .data_out_en        (data_out_en),
        .led                (led)
    );

    // ==============================
    // Concurrent checks
    // ==============================
    // No answer outside a responding message
    assert property (@(posedge sd_datInWrite_clk) disable iff (!sd_datInWrite_rst_)
                     data_out_en |-> resp_allowed)
    else begin
        $display("data_out_en went high for a message that must not answer");
        errors++;
    end

    // LED register only moves on LEDSet
    assert property (@(posedge sd_datInWrite_clk) disable iff (!sd_datInWrite_rst_)
                     !led_allowed |-> $stable(led))
    else begin
        $display("led changed without an LEDSet message");
        errors++;
    end

    // ==============================
    // Helpers
    // ==============================
    task automatic expect_value(input string name, input logic [63:0] exp,
                                input logic [63:0] got);
        checks++;
        assert (got === exp)
        else begin
            $display("ERR %s exp 0x%0h got 0x%0h", name, exp, got);
            errors++;
        end
    endtask

    // MSB first, one bit per cycle
    task automatic send_msg(input logic [63:0] m);
        for (int k = 63; k >= 0; k--) begin
            data_in = m[k];
            @(posedge sd_datInWrite_clk);
            #0.5;
        end
        data_in = 1'b0;
    endtask

    task automatic collect_resp(output logic [63:0] word, output int nbits);
        int wait_cnt;
        word     = '0;
        nbits    = 0;
        wait_cnt = 0;
        @(negedge sd_datInWrite_clk);
        while (!data_out_en && wait_cnt < 2 * `MSG_CYCLES) begin
            @(negedge sd_datInWrite_clk);
            wait_cnt++;
        end
        if (!data_out_en) begin
            $display("no response, data_out_en never rose");
            errors++;
        end
        while (data_out_en && nbits < 2 * `RESP_LEN) begin
            word = {word[62:0], data_out};
            nbits++;
            @(negedge sd_datInWrite_clk);
        end
        // Two idle cycles before the next message
        @(posedge sd_datInWrite_clk);
        @(posedge sd_datInWrite_clk);
        #0.5;
    endtask

    task automatic query(input logic [63:0] m, output logic [63:0] word);
        int nbits;
        resp_allowed = 1'b1;
        send_msg(m);
        collect_resp(word, nbits);
        resp_allowed = 1'b0;
        expect_value("data_out_en length", 64'(`RESP_LEN), 64'(nbits));
    endtask

    // Silent types run for the fixed decode time plus margin
    task automatic run_silent(input logic [63:0] m, input logic led_change);
        led_allowed = led_change;
        send_msg(m);
        repeat (`MSG_CYCLES + 8) @(posedge sd_datInWrite_clk);
        #0.5;
        led_allowed = 1'b0;
    endtask

    // Other words carry mode bits that differ from the ninth
    task automatic write_words(input int count, input logic [3:0] ninth_mode,
                               input logic [3:0] other_mode);
        for (int i = 0; i < count; i++) begin
            wr_trigger = 1'b1;
            if (i == 8) begin
                wr_data = {4'h3, ninth_mode, 8'h5A};
            end else begin
                wr_data = {4'hA, other_mode, 8'(i)};
            end
            @(posedge sd_datInWrite_clk);
            #0.5;
        end
        wr_trigger = 1'b0;
        wr_data    = '0;
    endtask

    task automatic close_test(input int num, input string name);
        tests_run++;
        if (errors == err_mark) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed, %0d errors", num, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    function automatic logic [63:0] status_word(input logic seen, input logic [3:0] mode);
        return {59'd0, seen, mode};
    endfunction

    // ==============================
    // Watchdog
    // ==============================
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

    // ==============================
    // Test sequence
    // ==============================
    initial begin
        logic [63:0] word;
        logic [55:0] arg_a;
        logic [55:0] arg_b;
        data_in      = 1'b0;
        wr_trigger   = 1'b0;
        wr_data      = '0;
        resp_allowed = 1'b0;
        led_allowed  = 1'b0;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        err_mark     = 0;
        arg_a        = 56'h12_3456_789A_BCDE;
        arg_b        = 56'hA5_5AF0_0FC3_3C96;

        @(posedge sd_datInWrite_rst_);
        @(posedge sd_datInWrite_clk);
        #0.5;

        expect_value("data_out_en", 64'd0, 64'(data_out_en));
        expect_value("led", 64'd0, 64'(led));
        close_test(1, "reset state");

        query({`TYPE_ECHO, arg_a}, word);
        expect_value("echo response", {8'h00, arg_a}, word);
        query({`TYPE_ECHO, arg_b}, word);
        expect_value("echo response", {8'h00, arg_b}, word);
        close_test(2, "echo");

        run_silent({`TYPE_LEDSET, 52'h1234_5678_9ABC_D, 4'hB}, 1'b1);
        expect_value("led", 64'hB, 64'(led));
        run_silent({`TYPE_NOP, 56'hFF_FFFF_FFFF_FFF4}, 1'b0);
        expect_value("led", 64'hB, 64'(led));
        close_test(3, "ledset and nop");

        query({`TYPE_SDSTATUS, 56'd0}, word);
        expect_value("sdstatus response", status_word(1'b0, 4'h0), word);
        write_words(32, 4'h5, 4'h9);
        query({`TYPE_SDSTATUS, 56'd0}, word);
        expect_value("sdstatus response", status_word(1'b1, 4'h5), word);
        close_test(4, "sdstatus first block");

        write_words(32, 4'hC, 4'h2);
        query({`TYPE_SDSTATUS, 56'd0}, word);
        expect_value("sdstatus response", status_word(1'b1, 4'hC), word);
        // Eight words stop just short of the ninth
        write_words(8, 4'h0, 4'h7);
        query({`TYPE_SDSTATUS, 56'd0}, word);
        expect_value("sdstatus response", status_word(1'b1, 4'hC), word);
        close_test(5, "sdstatus second block");

        run_silent({8'h9F, 56'h00_0000_0000_0003}, 1'b0);
        run_silent({8'hE7, 56'h00_0000_0000_0006}, 1'b0);
        expect_value("led", 64'hB, 64'(led));
        close_test(6, "unknown type");

        repeat (4) @(posedge sd_datInWrite_clk);
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+include
rtl/msg_pkg.sv
rtl/cycle_counter.sv
rtl/msg_fsm.sv
rtl/msg_shifter.sv
rtl/resp_shifter.sv
rtl/cmd_exec.sv
rtl/cmd6_capture.sv
rtl/spi_msg_top.sv
verification/tb_clk_gen.sv
verification/tb_spi_msg.sv

// ==== run.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_spi_msg -Mdir obj_dir

./obj_dir/Vtb_spi_msg > sim.log 2>&1 || true
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
    exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
    exit 1
fi
exit 0
